//--- include/alu_consts.svh
// ALU constants for word width, status flags and opcode field layout
`ifndef ALU_CONSTS_SVH
`define ALU_CONSTS_SVH

// Data path width
// Operands, results and the response word
`define ALU_WORD 16

// Half word
// Byte swap and sign extension boundary
`define ALU_BYTE 8

// Status register size
// One bit each for C Z N V
`define ALU_FLAGS 4

// Opcode block field
// Top bits of the opcode pick the compute unit
`define ALU_BLK_W 2

// Opcode function field
// Low bits select the operation inside the unit
`define ALU_FN_W 2

`endif

//--- rtl/alu_op_pkg.sv
// Operation encodings for the ALU opcode, compute units and status flag positions
`default_nettype none
`include "alu_consts.svh"

package alu_op_pkg;

	// Full opcode, block in the top bits and function below
	typedef enum logic [`ALU_BLK_W+`ALU_FN_W-1:0] {
		ADD  = 4'h0,	// a + b
		ADDC = 4'h1,	// a + b + C
		SUB  = 4'h2,	// a - b
		SUBC = 4'h3,	// a + ~b + C
		AND  = 4'h4,
		OR   = 4'h5,
		XOR  = 4'h6,
		BIC  = 4'h7,	// a & ~b
		RRC  = 4'h8,	// Rotate right through carry
		RRA  = 4'h9,	// Arithmetic right shift
		RLC  = 4'ha,	// Rotate left through carry
		SRL  = 4'hb,	// Logical right shift
		SWPB = 4'hc,
		SXT  = 4'hd,
		MOV  = 4'he,	// Passes b
		INV  = 4'hf
	} alu_op_t;

	// Compute unit, same order as the opcode block field
	typedef enum logic [`ALU_BLK_W-1:0] {
		ARITH,
		LOGIC,
		SHIFT,
		STRAY
	} alu_block_t;

	// Per unit functions
	typedef enum logic [`ALU_FN_W-1:0] {ARITH_ADD, ARITH_ADDC, ARITH_SUB, ARITH_SUBC} arith_fn_t;
	typedef enum logic [`ALU_FN_W-1:0] {LOGIC_AND, LOGIC_OR, LOGIC_XOR, LOGIC_BIC} logic_fn_t;
	typedef enum logic [`ALU_FN_W-1:0] {SHIFT_RRC, SHIFT_RRA, SHIFT_RLC, SHIFT_SRL} shift_fn_t;
	typedef enum logic [`ALU_FN_W-1:0] {STRAY_SWPB, STRAY_SXT, STRAY_MOV, STRAY_INV} stray_fn_t;

	// Bit positions in the status vector
	typedef enum logic [$clog2(`ALU_FLAGS)-1:0] {
		C,	// Carry, no borrow on subtract
		Z,	// Zero result
		N,	// Result MSB
		V	// Signed overflow
	} flag_bit_t;

endpackage : alu_op_pkg

`default_nettype wire

//--- rtl/alu_bus_pkg.sv
// Transaction types for the ALU request, response and status flags
`default_nettype none
`include "alu_consts.svh"

package alu_bus_pkg;
	import alu_op_pkg::*;

	// Flag values or write mask
	// Field order puts c at bit 0 to line up with flag_bit_t
	typedef struct packed {
		logic v;	// Signed overflow
		logic n;	// Negative
		logic z;	// Zero
		logic c;	// Carry
	} alu_flags_t;

	// One operation from the requester
	// Held stable while req is high
	typedef struct packed {
		alu_op_t op;
		logic [`ALU_WORD-1:0] a;	// First operand, also shift and stray source
		logic [`ALU_WORD-1:0] b;	// Second operand
	} alu_req_t;

	// Registered answer
	// Flags are the full status after the masked update
	typedef struct packed {
		logic [`ALU_WORD-1:0] res;
		alu_flags_t flags;
	} alu_resp_t;

endpackage : alu_bus_pkg

`default_nettype wire

//--- rtl/arith_unit.sv
// Arithmetic unit with one shared adder for add and subtract, with and without carry
`default_nettype none
`include "alu_consts.svh"

module arith_unit import alu_op_pkg::*; (
	input wire arith_fn_t fn,
	input wire [`ALU_WORD-1:0] a,
	input wire [`ALU_WORD-1:0] b,
	input wire cin,
	output logic [`ALU_WORD-1:0] res,
	output logic cout,	// No borrow on subtract
	output logic ovf	// Signed overflow
);

	logic [`ALU_WORD-1:0] opb;	// Adder second input, b or ~b
	logic carry_in;	// Adder carry in
	logic [`ALU_WORD:0] sum;	// Extra bit holds the carry out

	// Operand and carry steering
	always_comb begin
		opb = b;
		carry_in = 1'b0;
		case (fn)
			ARITH_ADD: begin
				opb = b;
				carry_in = 1'b0;
			end
			ARITH_ADDC: begin
				opb = b;
				carry_in = cin;	// Carry from status register
			end
			ARITH_SUB: begin
				opb = ~b;	// Two's complement negate
				carry_in = 1'b1;
			end
			ARITH_SUBC: begin
				opb = ~b;
				carry_in = cin;	// Borrow when C is clear
			end
			default: begin
				opb = b;
				carry_in = 1'b0;
			end
		endcase
	end

	// Single adder for all four functions
	assign sum = {1'b0, a} + {1'b0, opb} + {{`ALU_WORD{1'b0}}, carry_in};
	assign res = sum[`ALU_WORD-1:0];
	assign cout = sum[`ALU_WORD];

	// Like signed inputs giving an unlike signed result
	assign ovf = (a[`ALU_WORD-1] == opb[`ALU_WORD-1]) &&
		(res[`ALU_WORD-1] != a[`ALU_WORD-1]);

endmodule : arith_unit

`default_nettype wire

//--- rtl/logic_unit.sv
// Logic unit computing bitwise AND, OR, XOR and bit clear of two words
`default_nettype none
`include "alu_consts.svh"

module logic_unit import alu_op_pkg::*; (
	input wire logic_fn_t fn,
	input wire [`ALU_WORD-1:0] a,
	input wire [`ALU_WORD-1:0] b,
	output logic [`ALU_WORD-1:0] res
);

	// No carry or overflow out of this unit
	always_comb begin
		case (fn)
			LOGIC_AND: begin
				res = a & b;
			end
			LOGIC_OR: begin
				res = a | b;
			end
			LOGIC_XOR: begin
				res = a ^ b;
			end
			LOGIC_BIC: begin
				res = a & ~b;	// Clear bits of a set in b
			end
			default: begin
				res = a & b;
			end
		endcase
	end

endmodule : logic_unit

`default_nettype wire

//--- rtl/shifter_unit.sv
// Shifter unit doing single bit rotates and shifts through carry
`default_nettype none
`include "alu_consts.svh"

module shifter_unit import alu_op_pkg::*; (
	input wire shift_fn_t fn,
	input wire [`ALU_WORD-1:0] a,	// Source word
	input wire cin,	// Carry from status register
	output logic [`ALU_WORD-1:0] res,
	output logic cout	// Bit shifted out
);

	// One bit per operation
	always_comb begin
		case (fn)
			SHIFT_RRC: begin
				res = {cin, a[`ALU_WORD-1:1]};	// Carry enters at the MSB
				cout = a[0];
			end
			SHIFT_RRA: begin
				res = {a[`ALU_WORD-1], a[`ALU_WORD-1:1]};	// Sign kept
				cout = a[0];
			end
			SHIFT_RLC: begin
				res = {a[`ALU_WORD-2:0], cin};	// Carry enters at the LSB
				cout = a[`ALU_WORD-1];
			end
			SHIFT_SRL: begin
				res = {1'b0, a[`ALU_WORD-1:1]};
				cout = a[0];
			end
			default: begin
				res = a;
				cout = cin;
			end
		endcase
	end

	// Right shifts lose bit 0
	// RLC is the only one pushing out the MSB

endmodule : shifter_unit

`default_nettype wire

//--- rtl/stray_op_unit.sv
// Stray operations unit for byte swap, sign extension, move and invert
`default_nettype none
`include "alu_consts.svh"

module stray_op_unit import alu_op_pkg::*; (
	input wire stray_fn_t fn,
	input wire [`ALU_WORD-1:0] a,
	input wire [`ALU_WORD-1:0] b,	// Only read by MOV
	output logic [`ALU_WORD-1:0] res
);

	always_comb begin
		case (fn)
			STRAY_SWPB: begin
				// High and low bytes exchanged
				res = {a[`ALU_BYTE-1:0], a[`ALU_WORD-1:`ALU_BYTE]};
			end
			STRAY_SXT: begin
				// Low byte sign copied upward
				res = {{(`ALU_WORD-`ALU_BYTE){a[`ALU_BYTE-1]}}, a[`ALU_BYTE-1:0]};
			end
			STRAY_MOV: begin
				res = b;	// Plain copy
			end
			STRAY_INV: begin
				res = ~a;	// Ones complement
			end
			default: begin
				res = b;
			end
		endcase
	end

	// Flags from this block come only from the result

endmodule : stray_op_unit

`default_nettype wire

//--- rtl/alu.sv
// ALU selecting one of four compute units by opcode block and building flags and write mask
`default_nettype none
`include "alu_consts.svh"

module alu import alu_op_pkg::*, alu_bus_pkg::*; (
	input wire alu_op_t op,
	input wire [`ALU_WORD-1:0] a,
	input wire [`ALU_WORD-1:0] b,
	input wire cin,
	output logic [`ALU_WORD-1:0] res,
	output alu_flags_t flags,	// New flag values
	output alu_flags_t flag_we	// Flags this op may write
);

	alu_block_t blk;	// Opcode top bits
	logic [`ALU_FN_W-1:0] fn;	// Opcode low bits
	logic [`ALU_WORD-1:0] arith_res;
	logic [`ALU_WORD-1:0] logic_res;
	logic [`ALU_WORD-1:0] shift_res;
	logic [`ALU_WORD-1:0] stray_res;
	logic arith_cout;
	logic arith_ovf;
	logic shift_cout;
	logic [`ALU_FLAGS-1:0] fl;	// Indexed by flag_bit_t
	logic [`ALU_FLAGS-1:0] we;

	assign blk = alu_block_t'(op[`ALU_FN_W +: `ALU_BLK_W]);
	assign fn = op[`ALU_FN_W-1:0];

	// Units all see the same operands, function cast per unit
	arith_unit u_arith (.fn(arith_fn_t'(fn)), .a(a), .b(b), .cin(cin),
		.res(arith_res), .cout(arith_cout), .ovf(arith_ovf));
	logic_unit u_logic (.fn(logic_fn_t'(fn)), .a(a), .b(b), .res(logic_res));
	shifter_unit u_shift (.fn(shift_fn_t'(fn)), .a(a), .cin(cin),
		.res(shift_res), .cout(shift_cout));
	stray_op_unit u_stray (.fn(stray_fn_t'(fn)), .a(a), .b(b), .res(stray_res));

	// Result select and flag logic
	always_comb begin
		case (blk)
			ARITH: res = arith_res;
			LOGIC: res = logic_res;
			SHIFT: res = shift_res;
			default: res = stray_res;
		endcase

		fl[Z] = ~|res;	// Zero
		fl[N] = res[`ALU_WORD-1];	// Sign
		fl[C] = (blk == SHIFT) ? shift_cout : arith_cout;
		fl[V] = arith_ovf;

		// Z and N always written
		we[Z] = 1'b1;
		we[N] = 1'b1;
		we[C] = (blk == ARITH) || (blk == SHIFT);
		we[V] = (blk == ARITH);	// Overflow only means something here
	end

	assign flags = alu_flags_t'(fl);
	assign flag_we = alu_flags_t'(we);

endmodule : alu

`default_nettype wire

//--- rtl/alu_exec.sv
// ALU execution block with req/ack handshake, status register and registered response
`default_nettype none
`include "alu_consts.svh"

module alu_exec import alu_bus_pkg::*; (
	input wire clk,
	input wire reset,
	input wire req,	// Four phase request
	output logic ack,
	input wire alu_req_t req_data,	// Stable while req is high
	output alu_resp_t resp
);

	// Handshake state
	typedef enum logic {
		IDLE,	// Waiting for req
		HOLD	// Ack up until req drops
	} state_t;

	state_t state;
	alu_flags_t status;	// Status register
	alu_flags_t alu_flags;	// Raw flags from the ALU
	alu_flags_t flag_we;	// Write mask from the ALU
	alu_flags_t status_next;	// Status after masked merge
	logic [`ALU_WORD-1:0] alu_res;

	// Combinational core, carry fed back from status
	alu alu_core (
		.op(req_data.op),
		.a(req_data.a),
		.b(req_data.b),
		.cin(status.c),
		.res(alu_res),
		.flags(alu_flags),
		.flag_we(flag_we)
	);

	// Unwritten flags keep their old value
	assign status_next = alu_flags_t'((status & ~flag_we) | (alu_flags & flag_we));

	assign ack = (state == HOLD);	// High one clock after accept

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			status <= '0;	// First carry in is 0
			resp <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (req) begin
						// Accept, one item in flight
						status <= status_next;
						resp.res <= alu_res;
						resp.flags <= status_next;
						state <= HOLD;
					end
				end
				HOLD: begin
					// Back-pressure holds ack and resp
					if (!req) begin
						state <= IDLE;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

endmodule : alu_exec

`default_nettype wire

//--- verif/alu_asserts.sv
// Handshake and response stability checks bound into the ALU execution block
`default_nettype none

module alu_asserts import alu_bus_pkg::*; (
	input wire clk,
	input wire reset,
	input wire req,
	input wire ack,
	input wire alu_resp_t resp
);
	timeunit 1ns;
	timeprecision 100ps;

	// Synchronous reset clears the handshake
	ack_low_in_reset: assert property (@(posedge clk) reset |=> !ack)
		else $error("ack was high after a reset cycle");

	ack_rises: assert property (@(posedge clk) disable iff (reset) (req && !ack) |=> ack)
		else $error("ack did not rise one cycle after req was accepted");

	// Back-pressure, nothing new taken while req stays up
	hold_stable: assert property (@(posedge clk) disable iff (reset)
		(req && ack) |=> (ack && $stable(resp)))
		else $error("ack or resp changed while req was held");

	ack_falls: assert property (@(posedge clk) disable iff (reset) (!req && ack) |=> !ack)
		else $error("ack did not fall one cycle after req dropped");

	no_new_result: assert property (@(posedge clk) disable iff (reset) !req |=> $stable(resp))
		else $error("resp changed without a new req");

endmodule : alu_asserts

bind alu_exec alu_asserts alu_asserts_inst (
	.clk(clk),
	.reset(reset),
	.req(req),
	.ack(ack),
	.resp(resp)
);

`default_nettype wire

//--- verif/alu_tb.sv
// Testbench for the ALU execution block with directed and random ops, back-pressure and a model
`default_nettype none
`include "alu_consts.svh"

module alu_tb import alu_op_pkg::*, alu_bus_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 4;
	localparam int DRIVE_DELAY = 2;	// After the rising edge
	localparam int NUM_RANDOM = 2000;
	localparam int NUM_DIRECTED = 12;
	localparam int CYCLES_PER_TXN = 8;	// Longest handshake with 3 hold cycles takes 7
	localparam int WATCHDOG_NS =
		(NUM_RANDOM + NUM_DIRECTED + RESET_CYCLES) * CYCLES_PER_TXN * CLK_PERIOD;
	localparam int WORD_MAX = (1 << `ALU_WORD) - 1;
	localparam int SIGNED_MAX = (1 << (`ALU_WORD - 1)) - 1;
	localparam int SIGNED_MIN = -(1 << (`ALU_WORD - 1));

	logic clk;
	logic reset;
	logic req;
	logic ack;
	alu_req_t req_data;
	alu_resp_t resp;

	alu_flags_t model_status;	// Reference copy of the status register
	logic verdict_printed;	// Set once a final message is out

	alu_exec alu_exec_inst (
		.clk(clk),
		.reset(reset),
		.req(req),
		.ack(ack),
		.req_data(req_data),
		.resp(resp)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Expected result and full status after one op
	function automatic alu_resp_t model_step(input alu_op_t op, input logic [`ALU_WORD-1:0] a,
		input logic [`ALU_WORD-1:0] b, input alu_flags_t st);
		alu_resp_t out;
		alu_flags_t fl;
		logic [`ALU_WORD-1:0] r;
		int ua;
		int ub;
		int sa;
		int sb;
		int usum;
		int ssum;
		ua = int'(a);
		ub = int'(b);
		sa = int'($signed(a));
		sb = int'($signed(b));
		fl = st;	// Flags not written carry over
		r = '0;
		case (op)
			ADD, ADDC: begin
				usum = ua + ub + ((op == ADDC) ? int'(st.c) : 0);
				ssum = sa + sb + ((op == ADDC) ? int'(st.c) : 0);
				r = usum[`ALU_WORD-1:0];
				fl.c = (usum > WORD_MAX);
				fl.v = (ssum > SIGNED_MAX) || (ssum < SIGNED_MIN);
			end
			SUB, SUBC: begin
				// SUBC borrows one when C is clear
				usum = ua - ub - ((op == SUBC) ? 1 - int'(st.c) : 0);
				ssum = sa - sb - ((op == SUBC) ? 1 - int'(st.c) : 0);
				r = usum[`ALU_WORD-1:0];
				fl.c = (usum >= 0);	// Carry means no borrow
				fl.v = (ssum > SIGNED_MAX) || (ssum < SIGNED_MIN);
			end
			AND: r = a & b;
			OR: r = a | b;
			XOR: r = a ^ b;
			BIC: r = a & ~b;
			RRC: begin
				r = a >> 1;
				r[`ALU_WORD-1] = st.c;	// Old carry in at the top
				fl.c = a[0];
			end
			RRA: begin
				r = a >> 1;
				r[`ALU_WORD-1] = a[`ALU_WORD-1];
				fl.c = a[0];
			end
			RLC: begin
				r = a << 1;
				r[0] = st.c;
				fl.c = a[`ALU_WORD-1];
			end
			SRL: begin
				r = a >> 1;
				fl.c = a[0];
			end
			SWPB: r = (a << `ALU_BYTE) | (a >> `ALU_BYTE);
			SXT: begin
				usum = ua % (1 << `ALU_BYTE);	// Low byte as unsigned
				if (usum >= (1 << (`ALU_BYTE - 1)))
					usum = usum - (1 << `ALU_BYTE);
				r = usum[`ALU_WORD-1:0];
			end
			MOV: r = b;
			INV: r = ~a;
			default: r = '0;
		endcase
		fl.z = (r == '0);
		fl.n = r[`ALU_WORD-1];
		out.res = r;
		out.flags = fl;
		return out;
	endfunction

	task automatic check_resp(input alu_op_t op, input alu_resp_t expected);
		assert (resp === expected) else begin
			$display("FAIL at %0t ns: op %s expected res %h flags %b, got res %h flags %b",
				$time, op.name(), expected.res, expected.flags, resp.res, resp.flags);
			verdict_printed = 1'b1;
			$display("Simulation FAILED");
			$fatal(1, "response mismatch");
		end
	endtask

	// One full four phase handshake, req held for extra cycles after ack
	task automatic run_txn(input alu_op_t op, input logic [`ALU_WORD-1:0] a,
		input logic [`ALU_WORD-1:0] b, input int hold_cycles);
		alu_resp_t expected;
		expected = model_step(op, a, b, model_status);
		@(posedge clk);
		#DRIVE_DELAY;
		req_data.op = op;
		req_data.a = a;
		req_data.b = b;
		req = 1'b1;
		@(negedge clk);
		while (!ack) @(negedge clk);	// Mid cycle sample
		check_resp(op, expected);
		model_status = expected.flags;
		repeat (hold_cycles) @(posedge clk);	// Back-pressure
		@(posedge clk);
		#DRIVE_DELAY;
		req = 1'b0;
		req_data.a = ~a;	// Junk on the bus must not reach resp
		req_data.b = ~b;
		@(negedge clk);
		while (ack) @(negedge clk);
	endtask

	initial begin
		#WATCHDOG_NS;
		verdict_printed = 1'b1;
		$display("Simulation FAILED");
		$fatal(1, "timeout: handshake never completed");
	end

	initial begin
		logic [31:0] rnd;
		alu_op_t op;
		logic [`ALU_WORD-1:0] a;
		logic [`ALU_WORD-1:0] b;
		int hold;
		reset = 1'b1;
		req = 1'b0;
		req_data = '0;
		model_status = '0;	// Matches the status after reset
		verdict_printed = 1'b0;
		void'($urandom(32'h24ea6bda));
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		reset = 1'b0;

		run_txn(ADDC, 16'h1234, 16'h0001, 0);	// Carry in of 0 from reset
		run_txn(ADD, 16'hffff, 16'h0001, 1);	// Zero with carry out
		run_txn(ADDC, 16'h0001, 16'h0001, 0);	// Uses that carry
		run_txn(SUB, 16'h5555, 16'h5555, 2);	// Equal operands give Z
		run_txn(SUBC, 16'h0010, 16'h0001, 0);
		run_txn(SUB, 16'h0001, 16'h0002, 0);	// Borrow, C clear, N set
		run_txn(SUBC, 16'h0005, 16'h0001, 3);	// Consumes the borrow
		run_txn(ADD, 16'h7fff, 16'h0001, 0);	// Signed overflow
		run_txn(AND, 16'hf0f0, 16'h0f0f, 0);	// V and C left alone
		run_txn(RLC, 16'h8000, 16'h0000, 0);
		run_txn(RRC, 16'h0001, 16'h0000, 1);	// Carry enters the MSB
		run_txn(SXT, 16'h0080, 16'h0000, 0);

		for (int i = 0; i < NUM_RANDOM; i++) begin
			rnd = $urandom;
			op = alu_op_t'(rnd[`ALU_BLK_W+`ALU_FN_W-1:0]);
			rnd = $urandom;
			a = rnd[`ALU_WORD-1:0];
			rnd = $urandom;
			b = rnd[`ALU_WORD-1:0];
			if ($urandom_range(0, 7) == 0)
				b = a;	// More zero results
			hold = $urandom_range(0, 3);
			run_txn(op, a, b, hold);
		end

		verdict_printed = 1'b1;
		$display("Simulation PASSED");
		$finish;
	end

	// Run stopped early by a bound assertion
	final begin
		if (!verdict_printed)
			$display("Simulation FAILED");
	end

endmodule : alu_tb

`default_nettype wire

//--- list.f
+incdir+include
rtl/alu_op_pkg.sv
rtl/alu_bus_pkg.sv
rtl/arith_unit.sv
rtl/logic_unit.sv
rtl/shifter_unit.sv
rtl/stray_op_unit.sv
rtl/alu.sv
rtl/alu_exec.sv
verif/alu_asserts.sv
verif/alu_tb.sv

//--- Makefile
# Verilator build and run of the ALU execution block testbench

SRCS := $(shell grep -v '^+' list.f)
HDRS := $(wildcard include/*.svh)

.PHONY: all run clean

all: obj_dir/Valu_tb

# Rebuilt only when a source, header or the file list changes
obj_dir/Valu_tb: list.f $(SRCS) $(HDRS)
	verilator --binary --assert --timing --timescale 1ns/100ps --top-module alu_tb -f list.f

# Exit status of the simulator is the verdict
run: obj_dir/Valu_tb
	./obj_dir/Valu_tb

clean:
	rm -rf obj_dir
